//--- flist.f
hw/mult_pkg.sv
hw/mult_pipe.sv
hw/product_ram.sv
hw/block_ctrl.sv
hw/mult_block_top.sv
testbench/mult_block_checker.sv
testbench/tb_mult_block.sv

//--- run.sh
#!/usr/bin/env bash
# build with verilator, run, and scan the log for a failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mult_block -f flist.f \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_mult_block > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && exit 1
exit 0

//--- testbench/tb_mult_block.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mult_block;

    localparam int LOG_DEPTH     = 4;
    localparam int NUM_BLOCKS    = 3;
    localparam int FILL_TIMEOUT  = 400;
    localparam int VALID_TIMEOUT = 20;

    logic                    clk;
    logic                    rst;
    logic                    en_mult;
    mult_pkg::operand_pair_t operands;
    logic                    rdy_mult;
    logic                    block_read;
    logic                    block_full;
    logic                    mem_valid;
    mult_pkg::product_t      mem_data;

    int mismatch_count;
    int other_count;
    int timeout_count;

    // 100 ns period
    always #50 clk = ~clk;

    mult_block_top #(
        .LOG_DEPTH (LOG_DEPTH)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .en_mult    (en_mult),
        .operands   (operands),
        .rdy_mult   (rdy_mult),
        .block_read (block_read),
        .block_full (block_full),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data)
    );

    mult_block_checker #(
        .LOG_DEPTH (LOG_DEPTH)
    ) u_checker (
        .clk            (clk),
        .rst            (rst),
        .en_mult        (en_mult),
        .operands       (operands),
        .rdy_mult       (rdy_mult),
        .block_read     (block_read),
        .block_full     (block_full),
        .mem_valid      (mem_valid),
        .mem_data       (mem_data),
        .mismatch_count (mismatch_count),
        .other_count    (other_count)
    );

    // one clock of random operand traffic
    // stray reads only while operands are still taken, so full is far off
    task automatic drive_cycle(input logic stray_ok, input logic read_now);
        @(posedge clk);
        en_mult <= (($urandom % 10) < 7);
        if (($urandom % 8) == 0) begin
            operands <= '1;
        end else begin
            operands.a <= mult_pkg::operand_t'($urandom);
            operands.b <= mult_pkg::operand_t'($urandom);
        end
        block_read <= read_now || (stray_ok && rdy_mult === 1'b1 && ($urandom % 6) == 0);
    endtask

    initial begin
        int blk;
        int wait_cnt;
        int delay;
        void'($urandom(32'h5be4_a61f));
        clk           = 1'b0;
        rst           = 1'b1;
        en_mult       = 1'b0;
        operands      = '0;
        block_read    = 1'b0;
        timeout_count = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (blk = 0; blk < NUM_BLOCKS; blk++) begin
            // fill phase
            wait_cnt = 0;
            while (block_full !== 1'b1 && wait_cnt < FILL_TIMEOUT) begin
                drive_cycle(1'b1, 1'b0);
                wait_cnt++;
            end
            if (block_full !== 1'b1) begin
                $display("timeout: block_full never rose in block %0d", blk);
                timeout_count++;
                break;
            end
            // operands keep coming while full
            delay = $urandom % 6;
            repeat (delay) drive_cycle(1'b0, 1'b0);
            drive_cycle(1'b0, 1'b1);
            wait_cnt = 0;
            while (mem_valid !== 1'b1 && wait_cnt < VALID_TIMEOUT) begin
                drive_cycle(1'b0, 1'b0);
                wait_cnt++;
            end
            if (mem_valid !== 1'b1) begin
                $display("timeout: readout of block %0d never started", blk);
                timeout_count++;
                break;
            end
            wait_cnt = 0;
            while (mem_valid === 1'b1 && wait_cnt < VALID_TIMEOUT + 2**LOG_DEPTH) begin
                drive_cycle(1'b0, 1'b0);
                wait_cnt++;
            end
            if (mem_valid === 1'b1) begin
                $display("timeout: readout of block %0d never ended", blk);
                timeout_count++;
                break;
            end
        end
        repeat (3) drive_cycle(1'b0, 1'b0);
        $display("summary: mismatches %0d, other errors %0d, timeouts %0d",
                 mismatch_count, other_count, timeout_count);
        if (mismatch_count == 0 && other_count == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/mult_block_checker.sv
`timescale 1ns/10ps
`default_nettype none

module mult_block_checker #(
    parameter int LOG_DEPTH = 6
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    en_mult,
    input  wire mult_pkg::operand_pair_t operands,
    input  wire logic                    rdy_mult,
    input  wire logic                    block_read,
    input  wire logic                    block_full,
    input  wire logic                    mem_valid,
    input  wire mult_pkg::product_t      mem_data,
    output int                           mismatch_count,
    output int                           other_count
);

    localparam int DEPTH = 2**LOG_DEPTH;

    // products of accepted pairs, oldest at the front
    mult_pkg::product_t model_q[$];

    // accepts in the block being filled
    int   block_accepts;
    // cycles since the last accept of a block
    int   full_age;
    // cycles since the honored block_read
    int   rd_cnt;
    logic reading;

    // unsigned product done in 64-bit arithmetic
    function automatic mult_pkg::product_t unsigned_product(input mult_pkg::operand_pair_t p);
        longint unsigned wa;
        longint unsigned wb;
        wa = p.a;
        wb = p.b;
        return mult_pkg::product_t'(wa * wb);
    endfunction

    initial begin
        mismatch_count = 0;
        other_count    = 0;
    end

    always @(posedge clk) begin
        mult_pkg::product_t want;
        logic exp_rdy;
        logic exp_full;
        logic in_window;
        if (rst) begin
            model_q.delete();
            block_accepts = 0;
            full_age      = 0;
            rd_cnt        = 0;
            reading       = 1'b0;
        end else begin
            if (block_accepts == DEPTH) full_age++;
            if (reading) rd_cnt++;
            // data words land 2 to DEPTH+1 cycles after the request
            in_window = reading && (rd_cnt >= 2) && (rd_cnt <= DEPTH + 1);
            exp_rdy   = !(reading && (rd_cnt <= DEPTH)) && (block_accepts < DEPTH);
            // 2 pipe cycles, write edge, then full is visible
            exp_full  = (block_accepts == DEPTH) && (full_age >= 3);
            if (rdy_mult !== exp_rdy) begin
                mismatch_count++;
                $display("mismatch at %0t: rdy_mult is %b, expected %b", $time, rdy_mult, exp_rdy);
            end
            if (block_full !== exp_full) begin
                mismatch_count++;
                $display("mismatch at %0t: block_full is %b, expected %b",
                         $time, block_full, exp_full);
            end
            if (block_full === 1'b1 && model_q.size() != DEPTH) begin
                other_count++;
                $display("block_full at %0t with %0d products in the model instead of %0d",
                         $time, model_q.size(), DEPTH);
            end
            if (in_window) begin
                if (mem_valid !== 1'b1) begin
                    mismatch_count++;
                    $display("mismatch at %0t: mem_valid low in readout cycle %0d", $time, rd_cnt);
                end else if (model_q.size() == 0) begin
                    other_count++;
                    $display("readout word at %0t with no accepted pair left in the model", $time);
                end else begin
                    want = model_q.pop_front();
                    if (mem_data !== want) begin
                        mismatch_count++;
                        $display("mismatch at %0t: mem_data %h, expected %h", $time, mem_data, want);
                    end
                end
            end else if (mem_valid !== 1'b0) begin
                mismatch_count++;
                $display("mismatch at %0t: mem_valid high outside a readout", $time);
            end
            // whole block gone before new pairs are counted
            if (reading && rd_cnt == DEPTH + 1 && model_q.size() != 0) begin
                other_count++;
                $display("model still holds %0d products after readout at %0t",
                         model_q.size(), $time);
            end
            if (reading && rd_cnt == DEPTH + 2) reading = 1'b0;
            if (en_mult && rdy_mult) begin
                model_q.push_back(unsigned_product(operands));
                block_accepts++;
                if (block_accepts == DEPTH) full_age = 0;
            end
            // honored request starts the readout window
            if (!reading && block_read && block_full) begin
                reading       = 1'b1;
                rd_cnt        = 0;
                block_accepts = 0;
                full_age      = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mult_block_top.sv
`timescale 1ns/10ps
`default_nettype none

module mult_block_top #(
    parameter int LOG_DEPTH = 6
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    en_mult,
    input  wire mult_pkg::operand_pair_t operands,
    output logic                         rdy_mult,
    input  wire logic                    block_read,
    output logic                         block_full,
    output logic                         mem_valid,
    output mult_pkg::product_t           mem_data
);

    // pipe to controller and ram
    logic               accept;
    logic               res_valid;
    mult_pkg::product_t res_product;

    // controller to ram
    logic                 wr_en;
    logic [LOG_DEPTH-1:0] wr_addr;
    logic                 rd_en;
    logic [LOG_DEPTH-1:0] rd_addr;

    mult_pipe u_pipe (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (accept),
        .in_pair     (operands),
        .res_valid   (res_valid),
        .res_product (res_product)
    );

    block_ctrl #(
        .LOG_DEPTH (LOG_DEPTH)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .en_mult    (en_mult),
        .rdy_mult   (rdy_mult),
        .accept     (accept),
        .res_valid  (res_valid),
        .block_read (block_read),
        .block_full (block_full),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr)
    );

    // readout strobe and data come straight off the ram
    product_ram #(
        .LOG_DEPTH (LOG_DEPTH)
    ) u_ram (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (res_product),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_valid (mem_valid),
        .rd_data  (mem_data)
    );

endmodule

`default_nettype wire

//--- hw/block_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module block_ctrl #(
    parameter int LOG_DEPTH = 6
) (
    input  wire logic                 clk,
    input  wire logic                 rst,

    // operand side
    input  wire logic                 en_mult,
    output logic                      rdy_mult,
    output logic                      accept,

    // product from the pipe
    input  wire logic                 res_valid,

    // readout request and status
    input  wire logic                 block_read,
    output logic                      block_full,

    // ram write port control
    output logic                      wr_en,
    output logic [LOG_DEPTH-1:0]      wr_addr,

    // ram read port control
    output logic                      rd_en,
    output logic [LOG_DEPTH-1:0]      rd_addr
);

    mult_pkg::ctrl_state_t state_q;
    mult_pkg::ctrl_state_t state_d;

    // one extra bit, msb set means the block is spoken for
    logic [LOG_DEPTH:0]   accept_cnt;

    // next write address, moves with each product
    logic [LOG_DEPTH-1:0] wr_ptr;

    // next read address during readout
    logic [LOG_DEPTH-1:0] rd_ptr;

    logic last_write;
    logic last_read;
    logic readout_done;

    // block boundaries
    assign last_write   = res_valid && (wr_ptr == '1);
    assign last_read    = (state_q == mult_pkg::READ) && (rd_ptr == '1);
    assign readout_done = last_read;

    // take operands only while filling and room is left
    // counts accepts, not writes, so in-flight products are covered
    assign rdy_mult = ((state_q == mult_pkg::IDLE) || (state_q == mult_pkg::WRITE))
                      && !accept_cnt[LOG_DEPTH];
    assign accept   = en_mult && rdy_mult;

    // products go straight into the ram
    assign wr_en   = res_valid;
    assign wr_addr = wr_ptr;

    // readout strobes
    assign rd_en   = (state_q == mult_pkg::READ);
    assign rd_addr = rd_ptr;

    assign block_full = (state_q == mult_pkg::FULL);

    // next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            mult_pkg::IDLE: begin
                // first accepted pair starts the block
                if (accept) begin
                    state_d = mult_pkg::WRITE;
                end
            end
            mult_pkg::WRITE: begin
                // last address written
                if (last_write) begin
                    state_d = mult_pkg::FULL;
                end
            end
            mult_pkg::FULL: begin
                if (block_read) begin
                    state_d = mult_pkg::READ;
                end
            end
            mult_pkg::READ: begin
                if (last_read) begin
                    state_d = mult_pkg::IDLE;
                end
            end
            default: state_d = mult_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= mult_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // counters, all cleared when a readout finishes
    always_ff @(posedge clk) begin
        if (rst || readout_done) begin
            accept_cnt <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
        end else begin
            if (accept) begin
                accept_cnt <= accept_cnt + 1'b1;
            end
            if (res_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // closed block holds exactly one full count, no operand taken after it
    a_closed_count: assert property (@(posedge clk) disable iff (rst)
        (state_q inside {mult_pkg::FULL, mult_pkg::READ})
        |-> (accept_cnt[LOG_DEPTH] && (accept_cnt[LOG_DEPTH-1:0] == '0)));

    // pipe must be drained before full, nothing lands late
    a_no_late_product: assert property (@(posedge clk) disable iff (rst)
        (state_q inside {mult_pkg::FULL, mult_pkg::READ}) |-> !res_valid);

endmodule

`default_nettype wire

//--- hw/product_ram.sv
`timescale 1ns/10ps
`default_nettype none

module product_ram #(
    parameter int LOG_DEPTH = 6
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 wr_en,
    input  wire logic [LOG_DEPTH-1:0] wr_addr,
    input  wire mult_pkg::product_t   wr_data,
    input  wire logic                 rd_en,
    input  wire logic [LOG_DEPTH-1:0] rd_addr,
    output logic                      rd_valid,
    output mult_pkg::product_t        rd_data
);

    // one word per block entry
    mult_pkg::product_t mem [2**LOG_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // strobe follows the read request
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // controller never overlaps fill and readout
    a_no_rw_overlap: assert property (@(posedge clk) disable iff (rst) !(wr_en && rd_en));

endmodule

`default_nettype wire

//--- hw/mult_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module mult_pipe (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    in_valid,
    input  wire mult_pkg::operand_pair_t in_pair,
    output logic                         res_valid,
    output mult_pkg::product_t           res_product
);

    // stage 1 operand registers
    mult_pkg::operand_t a_q;
    mult_pkg::operand_t b_q;
    logic               valid_q;

    // valid bits shift alongside the data
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q   <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            valid_q   <= in_valid;
            res_valid <= valid_q;
        end
    end

    // payload path, loads every cycle
    always_ff @(posedge clk) begin
        a_q <= in_pair.a;
        b_q <= in_pair.b;
        // widen before multiply so the upper half is kept
        res_product <= mult_pkg::product_t'(a_q) * mult_pkg::product_t'(b_q);
    end

endmodule

`default_nettype wire

//--- hw/mult_pkg.sv
`default_nettype none

package mult_pkg;

    // operand width is fixed by the source interface
    localparam int OPERAND_W = 16;

    // full unsigned product, no truncation
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // controller state encoding width, shared with waveform decode
    localparam int STATE_W = 2;

    // one unsigned operand
    typedef logic [OPERAND_W-1:0] operand_t;

    // one unsigned product as stored in the block
    typedef logic [PRODUCT_W-1:0] product_t;

    // operand pair offered by the source in one beat
    typedef struct packed {
        operand_t a;
        operand_t b;
    } operand_pair_t;

    // block controller states
    typedef enum logic [STATE_W-1:0] {
        IDLE  = 2'd0,
        WRITE = 2'd1,
        FULL  = 2'd2,
        READ  = 2'd3
    } ctrl_state_t;

endpackage

`default_nettype wire
